// File: common/catch_params.svh
// catch game constants for canvas geometry, tick rates, credits and colours
`ifndef CATCH_PARAMS_SVH
`define CATCH_PARAMS_SVH

// canvas geometry, 160 x 120 pixels
`define MAX_X              159
`define PLAYER_ROW         112
`define CATCH_ROW          111   // one row above the player

// start positions
`define PLAYER_START_X     47
`define FRUIT_SPACING      24    // fruit i falls in column spacing*(i+1)

`define NUM_FRUITS         4

// 3-bit rgb
`define PLAYER_COLOUR      3'b100

// tick periods in clock cycles
// kept short so a full round fits in a short simulation
`define PLAYER_TICK_CYCLES 16
`define FRUIT_TICK_CYCLES  4
`define SECOND_CYCLES      64

// round length in second ticks
`define ROUND_SECONDS      60

// writes the frame buffer can take before a credit comes back
`define PLOT_CREDITS       4

`endif

// File: common/catch_pkg.sv
// catch game types for coordinates, colours, score, time, pixel writes and sprite states
package catch_pkg;

    // one pixel column or row up to 159
    typedef logic [7:0] coord_t;

    // rgb, one bit per channel, zero is black
    typedef logic [2:0] colour_t;

    // fruits caught this round
    typedef logic [7:0] score_t;

    // seconds left in the round
    typedef logic [7:0] time_t;

    // one frame-buffer write
    typedef struct packed
    {
        coord_t  x;
        coord_t  y;
        colour_t colour;
    } pixel_t;

    // sprite move sequence
    typedef enum logic [1:0]
    {
        IDLE,   // waiting for a tick
        ERASE,  // black pixel at old position
        STEP,   // position update
        DRAW    // colour at new position
    } sprite_state_t;

endpackage

// File: hdl/tick_divider.sv
// tick divider: one-cycle tick pulse every PERIOD clock cycles
`timescale 1ns/1ps

module tick_divider
#(
    parameter int PERIOD = 4
)
(
    input  logic clk,
    input  logic reset_n,
    output logic tick
);
    localparam int CW = (PERIOD > 1) ? $clog2(PERIOD) : 1;

    logic [CW-1:0] count_q;
    logic          wrap;

    assign wrap = (count_q == CW'(PERIOD - 1));

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            count_q <= '0;
            tick    <= 1'b0;
        end
        else
        begin
            count_q <= wrap ? '0 : count_q + CW'(1);
            tick    <= wrap;    // registered so the first tick lands PERIOD cycles out
        end
    end

endmodule

// File: sprite/sprite_mover.sv
// sprite mover: erases, steps and redraws a one-pixel player or fruit through the plot arbiter
`include "catch_params.svh"
`timescale 1ns/1ps

module sprite_mover
#(
    parameter bit         IS_FRUIT  = 1'b0,
    parameter int         START_X   = 0,
    parameter logic [7:0] LFSR_SEED = 8'h01
)
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              tick,
    input  logic              step_left,
    input  logic              step_right,
    input  logic              wr_grant,
    output logic              wr_req,
    output catch_pkg::pixel_t wr_pixel,
    output catch_pkg::pixel_t pos,
    output logic              landed
);
    import catch_pkg::*;

    localparam coord_t START_Y = IS_FRUIT ? coord_t'(0) : coord_t'(`PLAYER_ROW);

    sprite_state_t state_q;
    coord_t        x_q;
    coord_t        y_q;
    logic [7:0]    lfsr_q;
    logic          lfsr_fb;
    logic          go_left_q;   // direction latched at the tick
    logic          can_left;
    logic          can_right;
    logic          move_pending;
    colour_t       colour;
    coord_t        next_y;

    // edge clamp, a held direction at the edge is not a move
    assign can_left  = step_left && (x_q != coord_t'(0));
    assign can_right = step_right && (x_q != coord_t'(`MAX_X));

    // fruits fall on every tick
    assign move_pending = IS_FRUIT ? 1'b1 : (can_left || can_right);

    // x^8 + x^6 + x^5 + x^4 + 1
    assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

    assign colour = IS_FRUIT ? colour_t'(lfsr_q[2:0]) : colour_t'(`PLAYER_COLOUR);
    assign next_y = y_q + coord_t'(1);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state_q   <= IDLE;
            x_q       <= coord_t'(START_X);
            y_q       <= START_Y;
            lfsr_q    <= LFSR_SEED;
            go_left_q <= 1'b0;
            landed    <= 1'b0;
        end
        else
        begin
            landed <= 1'b0;
            case (state_q)
                IDLE:
                begin
                    // ticks seen outside IDLE are dropped
                    if (tick && move_pending)
                    begin
                        state_q   <= ERASE;
                        go_left_q <= can_left;
                    end
                end
                ERASE:
                begin
                    if (wr_grant)
                        state_q <= STEP;
                end
                STEP:
                begin
                    state_q <= DRAW;
                    if (IS_FRUIT)
                    begin
                        if (y_q == coord_t'(`CATCH_ROW))
                        begin
                            y_q    <= '0;   // respawn at the top
                            lfsr_q <= {lfsr_q[6:0], lfsr_fb};   // new colour
                        end
                        else
                        begin
                            y_q    <= next_y;
                            landed <= (next_y == coord_t'(`CATCH_ROW));
                        end
                    end
                    else if (go_left_q)
                        x_q <= x_q - coord_t'(1);
                    else
                        x_q <= x_q + coord_t'(1);
                end
                DRAW:
                begin
                    if (wr_grant)
                        state_q <= IDLE;    // move done
                end
                default:
                    state_q <= IDLE;
            endcase
        end
    end

    assign wr_req = (state_q == ERASE) || (state_q == DRAW);

    // pixel is stable while the request waits, x and y only move in STEP
    always_comb
    begin
        wr_pixel.x      = x_q;
        wr_pixel.y      = y_q;
        wr_pixel.colour = (state_q == DRAW) ? colour : colour_t'(0);
    end

    assign pos = '{x: x_q, y: y_q, colour: colour};

endmodule

// File: hdl/pixel_arbiter.sv
// pixel arbiter: fixed-priority grant of sprite writes onto a credit-controlled plot port
`include "catch_params.svh"
`timescale 1ns/1ps

module pixel_arbiter
#(
    parameter int NUM_REQ = 5
)
(
    input  logic               clk,
    input  logic               reset_n,
    input  logic [NUM_REQ-1:0] wr_req,
    input  catch_pkg::pixel_t  wr_pixel [NUM_REQ],
    output logic [NUM_REQ-1:0] wr_grant,
    input  logic               credit_return,
    output logic               plot_valid,
    output catch_pkg::pixel_t  plot_pixel
);
    import catch_pkg::*;

    localparam int CW = $clog2(`PLOT_CREDITS + 1);
    localparam int SW = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

    logic [CW-1:0] credit_q;
    logic [SW-1:0] sel;
    logic          any_grant;
    pixel_t        sel_pixel;

    // lowest index wins, nothing granted without a credit
    always_comb
    begin
        wr_grant  = '0;
        sel       = '0;
        any_grant = 1'b0;
        for (int i = 0; i < NUM_REQ; i++)
        begin
            if (wr_req[i] && !any_grant && (credit_q != '0))
            begin
                wr_grant[i] = 1'b1;
                sel         = SW'(i);
                any_grant   = 1'b1;
            end
        end
    end

    assign sel_pixel = wr_pixel[sel];

    // credit is spent at grant, so the write in the output register is already paid for
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            credit_q <= CW'(`PLOT_CREDITS);
        else
            credit_q <= credit_q - CW'(any_grant) + CW'(credit_return);
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            plot_valid <= 1'b0;
        else
            plot_valid <= any_grant;    // one cycle after the grant
    end

    always_ff @(posedge clk)
    begin
        if (any_grant)
            plot_pixel <= sel_pixel;
    end

endmodule

// File: hdl/catch_scorer.sv
// catch scorer: counts fruits landing over the player and runs the round countdown
`include "catch_params.svh"
`timescale 1ns/1ps

module catch_scorer
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   second_tick,
    input  catch_pkg::coord_t      player_x,
    input  logic [`NUM_FRUITS-1:0] fruit_landed,
    input  catch_pkg::pixel_t      fruit_pos [`NUM_FRUITS],
    output catch_pkg::score_t      score,
    output catch_pkg::time_t       time_left
);
    import catch_pkg::*;

    logic [`NUM_FRUITS-1:0] over_player;
    logic                   catch_hit;
    logic                   round_end;

    // a fruit counts only in the cycle it lands on the catch row
    always_comb
    begin
        for (int i = 0; i < `NUM_FRUITS; i++)
            over_player[i] = fruit_landed[i] && (fruit_pos[i].x == player_x);
    end

    assign catch_hit = |over_player;    // one catch per cycle at most

    // timer would reach zero, reload instead
    assign round_end = second_tick && (time_left == time_t'(1));

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            time_left <= time_t'(`ROUND_SECONDS);
        else if (round_end)
            time_left <= time_t'(`ROUND_SECONDS);
        else if (second_tick)
            time_left <= time_left - time_t'(1);
    end

    // score clears together with the timer reload
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            score <= '0;
        else if (round_end)
            score <= '0;
        else if (catch_hit && (score != score_t'(8'hff)))
            score <= score + score_t'(1);   // holds at the top
    end

endmodule

// File: hdl/catch_top.sv
// catch top: fruit-catching game core with player, falling fruits, plot arbiter and scorer
`include "catch_params.svh"
`timescale 1ns/1ps

module catch_top
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              move_left,
    input  logic              move_right,
    input  logic              credit_return,
    output logic              plot_valid,
    output catch_pkg::pixel_t plot_pixel,
    output catch_pkg::score_t score,
    output catch_pkg::time_t  time_left
);
    import catch_pkg::*;

    localparam int NUM_REQ = `NUM_FRUITS + 1;   // player plus fruits

    logic                   player_tick;
    logic                   fruit_tick;
    logic                   second_tick;
    logic [NUM_REQ-1:0]     wr_req;
    logic [NUM_REQ-1:0]     wr_grant;
    pixel_t                 wr_pixel [NUM_REQ];
    pixel_t                 player_pos;
    pixel_t                 fruit_pos [`NUM_FRUITS];
    logic [`NUM_FRUITS-1:0] fruit_landed;

    tick_divider #(.PERIOD(`PLAYER_TICK_CYCLES)) u_player_tick
    (
        .clk     (clk),
        .reset_n (reset_n),
        .tick    (player_tick)
    );

    tick_divider #(.PERIOD(`FRUIT_TICK_CYCLES)) u_fruit_tick
    (
        .clk     (clk),
        .reset_n (reset_n),
        .tick    (fruit_tick)
    );

    tick_divider #(.PERIOD(`SECOND_CYCLES)) u_second_tick
    (
        .clk     (clk),
        .reset_n (reset_n),
        .tick    (second_tick)
    );

    // request 0 is the player, highest priority
    sprite_mover
    #(
        .IS_FRUIT  (1'b0),
        .START_X   (`PLAYER_START_X),
        .LFSR_SEED (8'h01)
    )
    u_player
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .tick       (player_tick),
        .step_left  (move_left),
        .step_right (move_right),
        .wr_grant   (wr_grant[0]),
        .wr_req     (wr_req[0]),
        .wr_pixel   (wr_pixel[0]),
        .pos        (player_pos),
        .landed     ()
    );

    for (genvar i = 0; i < `NUM_FRUITS; i++)
    begin : g_fruit
        sprite_mover
        #(
            .IS_FRUIT  (1'b1),
            .START_X   (`FRUIT_SPACING * (i + 1)),
            .LFSR_SEED (8'(8'h2b + i * 8'h35)) // distinct, never zero
        )
        u_fruit
        (
            .clk        (clk),
            .reset_n    (reset_n),
            .tick       (fruit_tick),
            .step_left  (1'b0),
            .step_right (1'b0),
            .wr_grant   (wr_grant[i+1]),
            .wr_req     (wr_req[i+1]),
            .wr_pixel   (wr_pixel[i+1]),
            .pos        (fruit_pos[i]),
            .landed     (fruit_landed[i])
        );
    end

    pixel_arbiter #(.NUM_REQ(NUM_REQ)) u_arbiter
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .wr_req        (wr_req),
        .wr_pixel      (wr_pixel),
        .wr_grant      (wr_grant),
        .credit_return (credit_return),
        .plot_valid    (plot_valid),
        .plot_pixel    (plot_pixel)
    );

    catch_scorer u_scorer
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .second_tick  (second_tick),
        .player_x     (player_pos.x),
        .fruit_landed (fruit_landed),
        .fruit_pos    (fruit_pos),
        .score        (score),
        .time_left    (time_left)
    );

endmodule

// File: verif/catch_assert.sv
// catch checker: concurrent checks on plot credits, plotted pixels, score and round timer
`include "catch_params.svh"
`timescale 1ns/1ps

module catch_assert
(
    input logic              clk,
    input logic              reset_n,
    input logic              credit_return,
    input logic              plot_valid,
    input catch_pkg::pixel_t plot_pixel,
    input catch_pkg::score_t score,
    input catch_pkg::time_t  time_left
);
    import catch_pkg::*;

    int unsigned fail_count = 0;
    int          outstanding;   // plots not yet paid back
    int          gap;           // cycles since time_left last moved
    logic        ticked;
    time_t       time_q;
    score_t      score_q;
    logic        reload;

    function automatic logic fruit_column(input coord_t x);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < `NUM_FRUITS; i++)
            if (x == coord_t'(`FRUIT_SPACING * (i + 1)))
                hit = 1'b1;
        return hit;
    endfunction

    assign reload = (time_q == time_t'(1)) && (time_left == time_t'(`ROUND_SECONDS));

    always_ff @(posedge clk)
    begin
        time_q  <= time_left;
        score_q <= score;
        if (!reset_n)
        begin
            outstanding <= 0;
            gap         <= 0;
            ticked      <= 1'b0;
        end
        else
        begin
            outstanding <= outstanding + int'(plot_valid) - int'(credit_return);
            gap         <= (time_left != time_q) ? 1 : gap + 1;
            if (time_left != time_q)
                ticked <= 1'b1;
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        (!reset_n && !$past(reset_n)) |-> !plot_valid)
    else
    begin
        fail_count = fail_count + 1;
        $error("ERROR %0t: plot during reset", $time);
    end

    a_credits: assert property (@(posedge clk) disable iff (!reset_n)
        (outstanding >= 0) && (outstanding <= `PLOT_CREDITS))
    else
    begin
        fail_count = fail_count + 1;
        $error("ERROR %0t: credits overrun", $time);
    end

    a_player_pixel: assert property (@(posedge clk) disable iff (!reset_n)
        (plot_valid && plot_pixel.y == coord_t'(`PLAYER_ROW)) |->
        (plot_pixel.x <= coord_t'(`MAX_X)) &&
        (plot_pixel.colour == '0 || plot_pixel.colour == colour_t'(`PLAYER_COLOUR)))
    else
    begin
        fail_count = fail_count + 1;
        $error("ERROR %0t: bad player pixel", $time);
    end

    a_fruit_pixel: assert property (@(posedge clk) disable iff (!reset_n)
        (plot_valid && plot_pixel.y != coord_t'(`PLAYER_ROW)) |->
        (plot_pixel.y <= coord_t'(`CATCH_ROW)) && fruit_column(plot_pixel.x))
    else
    begin
        fail_count = fail_count + 1;
        $error("ERROR %0t: bad fruit pixel", $time);
    end

    a_score_step: assert property (@(posedge clk) disable iff (!reset_n)
        (score != score_q) |-> (score == score_q + score_t'(1)) || (score == '0 && reload))
    else
    begin
        fail_count = fail_count + 1;
        $error("ERROR %0t: score jump", $time);
    end

    a_time_step: assert property (@(posedge clk) disable iff (!reset_n)
        (time_left != time_q) |-> (time_left == time_q - time_t'(1)) || reload)
    else
    begin
        fail_count = fail_count + 1;
        $error("ERROR %0t: timer jump", $time);
    end

    // one second between timer moves, never shorter or longer
    a_time_rate: assert property (@(posedge clk) disable iff (!reset_n)
        ticked |-> (gap <= `SECOND_CYCLES) && ((time_left == time_q) || (gap == `SECOND_CYCLES)))
    else
    begin
        fail_count = fail_count + 1;
        $error("ERROR %0t: timer rate", $time);
    end

    a_reload_clear: assert property (@(posedge clk) disable iff (!reset_n)
        reload |-> (score == '0))
    else
    begin
        fail_count = fail_count + 1;
        $error("ERROR %0t: score kept", $time);
    end

endmodule

bind catch_top catch_assert u_assert (.*);

// File: verif/catch_tb.sv
// catch testbench: drives the player through the edges, parks it under fruit 0 and idles two rounds
`include "catch_params.svh"
`timescale 1ns/1ps

module catch_tb;
    import catch_pkg::*;

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int EDGE_HOLD      = 4 * `PLAYER_TICK_CYCLES;   // lean on the edge a while
    localparam int CATCH_LIMIT    = 2 * `CATCH_ROW * `FRUIT_TICK_CYCLES * 8;

    logic   clk;
    logic   reset_n;
    logic   move_left;
    logic   move_right;
    logic   credit_return;
    logic   plot_valid;
    pixel_t plot_pixel;
    score_t score;
    time_t  time_left;

    integer seed = 32'h737d;
    int     cycle_count = 0;
    int     owed;              // plots seen but not yet returned
    int     plots_in_window;
    int     reloads;
    int     park_cycle;
    logic   caught;
    coord_t player_x;          // last drawn player column
    time_t  prev_time;
    score_t prev_score;

    catch_top u_dut
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .move_left     (move_left),
        .move_right    (move_right),
        .credit_return (credit_return),
        .plot_valid    (plot_valid),
        .plot_pixel    (plot_pixel),
        .score         (score),
        .time_left     (time_left)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic report_failure(input string what);
        $display("ERROR %0t: %s", $time, what);
        $display("** FAIL **");
        $fatal(1, "%s", what);
    endtask

    // one clock: sample outputs, pay back credits, track the player
    task automatic next_cycle();
        logic        give;
        logic        quiet;
        logic [31:0] r;
        int          dx;
        @(posedge clk);
        #1;
        r     = $random(seed);
        quiet = ((cycle_count / 100) % 8) == 7;   // 100-cycle stall windows
        give  = (owed > 0) && !quiet && (r[1:0] != 2'b00);
        owed  = owed - int'(give) + int'(plot_valid);
        credit_return = give;
        if (!quiet)
            plots_in_window = 0;
        else
            plots_in_window = plots_in_window + int'(plot_valid);
        assert (plots_in_window <= `PLOT_CREDITS)
            else report_failure("more plots than credits in a stall window");
        if (plot_valid && plot_pixel.y == coord_t'(`PLAYER_ROW) && plot_pixel.colour != '0)
        begin
            dx = int'(plot_pixel.x) - int'(player_x);
            assert (dx >= -1 && dx <= 1)
                else report_failure("player pixel jumped more than one column");
            player_x = plot_pixel.x;
        end
        if (time_left == time_t'(`ROUND_SECONDS) && prev_time == time_t'(1))
            reloads = reloads + 1;
        if (score != prev_score && score != '0)
            caught = 1'b1;
        prev_time  = time_left;
        prev_score = score;
    endtask

    // watchdog on the falling edge, away from the DUT updates
    always @(negedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (u_dut.u_assert.fail_count != 0)
            report_failure("bound checker flagged a rule violation");
        else if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the game phases did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    initial
    begin
        reset_n         = 1'b0;
        move_left       = 1'b0;
        move_right      = 1'b0;
        credit_return   = 1'b0;
        owed            = 0;
        plots_in_window = 0;
        reloads         = 0;
        park_cycle      = 0;
        caught          = 1'b0;
        player_x        = coord_t'(`PLAYER_START_X);
        prev_time       = time_t'(`ROUND_SECONDS);
        prev_score      = '0;
        repeat (16) @(posedge clk);
        #1;
        reset_n = 1'b1;

        move_left = 1'b1;   // walk to column 0 and push past it
        while (player_x != coord_t'(0))
            next_cycle();
        repeat (EDGE_HOLD) next_cycle();
        move_left  = 1'b0;
        move_right = 1'b1;
        while (player_x != coord_t'(`MAX_X))
            next_cycle();
        repeat (EDGE_HOLD) next_cycle();

        // back to fruit 0's column
        move_right = 1'b0;
        move_left  = 1'b1;
        while (player_x != coord_t'(`FRUIT_SPACING))
            next_cycle();
        move_left  = 1'b0;
        park_cycle = cycle_count;
        caught     = 1'b0;
        reloads    = 0;

        while (reloads < 2)
        begin
            next_cycle();
            assert (caught || (cycle_count - park_cycle) <= CATCH_LIMIT)
                else report_failure("no fruit caught with the player parked under fruit 0");
        end

        if (u_dut.u_assert.fail_count != 0 || !caught)
            report_failure("checks failed by the end of the run");
        else
        begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// File: src.f
+incdir+common
common/catch_pkg.sv
hdl/tick_divider.sv
sprite/sprite_mover.sv
hdl/pixel_arbiter.sv
hdl/catch_scorer.sv
hdl/catch_top.sv
verif/catch_assert.sv
verif/catch_tb.sv

// File: Makefile
# Verilator build for the catch game core

VERILATOR  = verilator
TOP        = catch_tb
FILELIST   = src.f
BUILD_DIR  = obj_dir
LINT_FLAGS = --lint-only --timing --assert --top-module $(TOP)
SIM_FLAGS  = --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
RUN_ARGS   = +verilator+error+limit+10

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)
